// File: design/bru_iq_defines.svh
// queue depth, dispatch width and register field width defines for the BRU issue queue

`ifndef BRU_IQ_DEFINES_SVH
`define BRU_IQ_DEFINES_SVH

// queue shape
`define BRU_IQ_ENTRIES 6
`define DISPATCH_WAYS 4

// physical register numbering
// low bits select the bank, upper bits select the row
`define LOG_PR_COUNT 7
`define LOG_PRF_BANK_COUNT 2

// reorder buffer
`define LOG_ROB_ENTRIES 7

`endif

// File: design/bru_iq_pkg.sv
// typedefs, packed structs and the lowest-set-bit helper for the BRU issue queue

`default_nettype none

`include "bru_iq_defines.svh"

package bru_iq_pkg;

    typedef logic [`LOG_PR_COUNT-1:0]                       pr_t;
    typedef logic [`LOG_PR_COUNT-`LOG_PRF_BANK_COUNT-1:0]   pr_upper_t;
    typedef logic [`LOG_PRF_BANK_COUNT-1:0]                 prf_bank_t;
    typedef logic [`LOG_ROB_ENTRIES-1:0]                    rob_index_t;
    typedef logic [3:0]                                     bru_op_t;
    typedef logic [31:0]                                    pc_t;
    typedef logic [19:0]                                    imm20_t;
    typedef logic [`BRU_IQ_ENTRIES-1:0]                     entry_vec_t;

    typedef struct packed {
        bru_op_t    op;
        pc_t        pc;
        imm20_t     imm20;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } bru_payload_t;

    typedef struct packed {
        pr_t  pr;
        logic unneeded;
        logic ready;
    } src_operand_t;

    // one dispatch way, or one stored entry
    typedef struct packed {
        logic         valid;
        bru_payload_t payload;
        src_operand_t a;
        src_operand_t b;
    } iq_op_t;

    typedef struct packed {
        logic      valid;
        pr_upper_t upper_pr;
    } wb_bus_t;

    typedef struct packed {
        bru_payload_t payload;
        logic         a_unneeded;
        logic         a_forward;
        prf_bank_t    a_bank;
        logic         b_unneeded;
        logic         b_forward;
        prf_bank_t    b_bank;
    } issue_op_t;

    typedef struct packed {
        logic valid;
        pr_t  pr;
    } prf_read_req_t;

    // isolate lowest set bit, zero in gives zero out
    function automatic entry_vec_t lowest_one_hot(entry_vec_t req);
        return req & (~req + entry_vec_t'(1));
    endfunction

endpackage

`default_nettype wire

// File: design/dispatch_alloc.sv
// dispatch allocation: cascaded free-entry grants per way, acks and the way-to-entry crossbar

`timescale 1ns/1ps
`default_nettype none

`include "bru_iq_defines.svh"

module dispatch_alloc (
    // dispatch by way
    input  logic [`DISPATCH_WAYS-1:0]                       dispatch_attempt_by_way,
    input  bru_iq_pkg::iq_op_t [`DISPATCH_WAYS-1:0]         dispatch_op_by_way,

    // occupancy from entry storage
    input  bru_iq_pkg::entry_vec_t                          valid_by_entry,

    output logic [`DISPATCH_WAYS-1:0]                       dispatch_ack_by_way,
    output bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0]        dispatch_by_entry
);

    // one-hot entry granted to each way, zero if none
    bru_iq_pkg::entry_vec_t [`DISPATCH_WAYS-1:0] grant_by_way;

    // --------------------------------------------------------------------------
    // cascaded grants

    // way 0 sees all free entries, each later way sees what is left
    always_comb begin
        bru_iq_pkg::entry_vec_t open_mask;

        open_mask = ~valid_by_entry;
        for (int way = 0; way < `DISPATCH_WAYS; way++) begin
            grant_by_way[way] = bru_iq_pkg::lowest_one_hot(open_mask)
                & {`BRU_IQ_ENTRIES{dispatch_attempt_by_way[way]}};
            open_mask = open_mask & ~grant_by_way[way];
            dispatch_ack_by_way[way] = |grant_by_way[way];
        end
    end

    // --------------------------------------------------------------------------
    // crossbar

    // at most one way lands on an entry, so a plain select is enough
    always_comb begin
        for (int entry = 0; entry < `BRU_IQ_ENTRIES; entry++) begin
            dispatch_by_entry[entry] = '0;
            for (int way = 0; way < `DISPATCH_WAYS; way++) begin
                if (grant_by_way[way][entry]) begin
                    dispatch_by_entry[entry] = dispatch_op_by_way[way];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/iq_entry_array.sv
// collapsing age-ordered entry storage with operand ready accumulation

`timescale 1ns/1ps
`default_nettype none

`include "bru_iq_defines.svh"

module iq_entry_array (
    input  logic                                            CLK,
    input  logic                                            nRST,

    // routed dispatch, zero where nothing lands
    input  bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0]        dispatch_by_entry,

    // from issue select
    input  bru_iq_pkg::entry_vec_t                          issue_mask,
    // [0] operand A, [1] operand B
    input  bru_iq_pkg::entry_vec_t [1:0]                    forward_by_entry,

    output bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0]        entries,
    output bru_iq_pkg::entry_vec_t                          valid_by_entry
);

    // entries with this cycle's wakeups folded in
    bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0] woken_by_entry;
    bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0] next_by_entry;

    always_comb begin
        for (int i = 0; i < `BRU_IQ_ENTRIES; i++) begin
            valid_by_entry[i] = entries[i].valid;
        end
    end

    always_comb begin
        for (int i = 0; i < `BRU_IQ_ENTRIES; i++) begin
            woken_by_entry[i] = entries[i];
            woken_by_entry[i].a.ready = entries[i].a.ready | forward_by_entry[0][i];
            woken_by_entry[i].b.ready = entries[i].b.ready | forward_by_entry[1][i];
        end
    end

    // --------------------------------------------------------------------------
    // collapse or hold

    always_comb begin
        // lower entries can take from the slot above
        for (int i = 0; i < `BRU_IQ_ENTRIES-1; i++) begin
            if (issue_mask[i]) begin
                if (entries[i+1].valid) begin
                    next_by_entry[i] = woken_by_entry[i+1];
                end
                else begin
                    next_by_entry[i] = dispatch_by_entry[i+1];
                end
            end
            else begin
                if (entries[i].valid) begin
                    next_by_entry[i] = woken_by_entry[i];
                end
                else begin
                    next_by_entry[i] = dispatch_by_entry[i];
                end
            end
        end

        // top entry has nothing above, so a shift empties it
        if (issue_mask[`BRU_IQ_ENTRIES-1]) begin
            next_by_entry[`BRU_IQ_ENTRIES-1] = '0;
        end
        else if (entries[`BRU_IQ_ENTRIES-1].valid) begin
            next_by_entry[`BRU_IQ_ENTRIES-1] = woken_by_entry[`BRU_IQ_ENTRIES-1];
        end
        else begin
            next_by_entry[`BRU_IQ_ENTRIES-1] = dispatch_by_entry[`BRU_IQ_ENTRIES-1];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entries <= '0;
        end
        else begin
            entries <= next_by_entry;
        end
    end

endmodule

`default_nettype wire

// File: design/issue_select.sv
// issue select: writeback forwarding, readiness, oldest-first pick, issue mux and PRF reads

`timescale 1ns/1ps
`default_nettype none

`include "bru_iq_defines.svh"

module issue_select (
    input  bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0]            entries,
    input  bru_iq_pkg::wb_bus_t [(1<<`LOG_PRF_BANK_COUNT)-1:0]  wb_bus_by_bank,
    input  logic                                                pipeline_ready,

    // back to entry storage
    output bru_iq_pkg::entry_vec_t                              issue_mask,
    // [0] operand A, [1] operand B
    output bru_iq_pkg::entry_vec_t [1:0]                        forward_by_entry,

    // to the BRU pipeline
    output logic                                                issue_valid,
    output bru_iq_pkg::issue_op_t                               issue_op,
    output bru_iq_pkg::prf_read_req_t                           prf_req_a,
    output bru_iq_pkg::prf_read_req_t                           prf_req_b
);

    bru_iq_pkg::entry_vec_t ready_by_entry;
    bru_iq_pkg::entry_vec_t issue_one_hot;

    // bus for the operand's bank carries its row this cycle
    function automatic logic is_forwarded(
        bru_iq_pkg::src_operand_t                           src,
        bru_iq_pkg::wb_bus_t [(1<<`LOG_PRF_BANK_COUNT)-1:0] bus
    );
        bru_iq_pkg::prf_bank_t bank;
        bank = bru_iq_pkg::prf_bank_t'(src.pr);
        return bus[bank].valid
            & (bus[bank].upper_pr == bru_iq_pkg::pr_upper_t'(src.pr >> `LOG_PRF_BANK_COUNT));
    endfunction

    always_comb begin
        for (int i = 0; i < `BRU_IQ_ENTRIES; i++) begin
            forward_by_entry[0][i] = is_forwarded(entries[i].a, wb_bus_by_bank);
            forward_by_entry[1][i] = is_forwarded(entries[i].b, wb_bus_by_bank);
            ready_by_entry[i] = pipeline_ready & entries[i].valid
                & (entries[i].a.unneeded | entries[i].a.ready | forward_by_entry[0][i])
                & (entries[i].b.unneeded | entries[i].b.ready | forward_by_entry[1][i]);
        end
    end

    // lowest index is oldest
    assign issue_one_hot = bru_iq_pkg::lowest_one_hot(ready_by_entry);
    // picked entry and everything above it, all zero when nothing picked
    assign issue_mask = ~(issue_one_hot - bru_iq_pkg::entry_vec_t'(1));

    // --------------------------------------------------------------------------
    // issue mux

    always_comb begin
        issue_valid = |ready_by_entry;
        issue_op = '0;
        prf_req_a = '0;
        prf_req_b = '0;
        for (int i = 0; i < `BRU_IQ_ENTRIES; i++) begin
            if (issue_one_hot[i]) begin
                issue_op.payload = entries[i].payload;
                issue_op.a_unneeded = entries[i].a.unneeded;
                issue_op.a_forward = forward_by_entry[0][i];
                issue_op.a_bank = bru_iq_pkg::prf_bank_t'(entries[i].a.pr);
                issue_op.b_unneeded = entries[i].b.unneeded;
                issue_op.b_forward = forward_by_entry[1][i];
                issue_op.b_bank = bru_iq_pkg::prf_bank_t'(entries[i].b.pr);
                // no read needed for forwarded or unused operands
                prf_req_a.valid = ~forward_by_entry[0][i] & ~entries[i].a.unneeded;
                prf_req_a.pr = entries[i].a.pr;
                prf_req_b.valid = ~forward_by_entry[1][i] & ~entries[i].b.unneeded;
                prf_req_b.pr = entries[i].b.pr;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/bru_iq.sv
// BRU issue queue top level: dispatch allocation, entry storage and issue select

`timescale 1ns/1ps
`default_nettype none

`include "bru_iq_defines.svh"

module bru_iq (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // op dispatch by way
    input  logic [`DISPATCH_WAYS-1:0]                           dispatch_attempt_by_way,
    input  bru_iq_pkg::iq_op_t [`DISPATCH_WAYS-1:0]             dispatch_op_by_way,
    output logic [`DISPATCH_WAYS-1:0]                           dispatch_ack_by_way,

    // BRU pipeline
    input  logic                                                pipeline_ready,

    // writeback bus by bank
    input  bru_iq_pkg::wb_bus_t [(1<<`LOG_PRF_BANK_COUNT)-1:0]  wb_bus_by_bank,

    // issue and register reads
    output logic                                                issue_valid,
    output bru_iq_pkg::issue_op_t                               issue_op,
    output bru_iq_pkg::prf_read_req_t                           prf_req_a,
    output bru_iq_pkg::prf_read_req_t                           prf_req_b
);

    bru_iq_pkg::entry_vec_t                         valid_by_entry;
    bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0]       dispatch_by_entry;
    bru_iq_pkg::iq_op_t [`BRU_IQ_ENTRIES-1:0]       entries;
    bru_iq_pkg::entry_vec_t                         issue_mask;
    bru_iq_pkg::entry_vec_t [1:0]                   forward_by_entry;

    dispatch_alloc u_dispatch_alloc (
        .dispatch_attempt_by_way (dispatch_attempt_by_way),
        .dispatch_op_by_way      (dispatch_op_by_way),
        .valid_by_entry          (valid_by_entry),
        .dispatch_ack_by_way     (dispatch_ack_by_way),
        .dispatch_by_entry       (dispatch_by_entry)
    );

    iq_entry_array u_iq_entry_array (
        .CLK               (CLK),
        .nRST              (nRST),
        .dispatch_by_entry (dispatch_by_entry),
        .issue_mask        (issue_mask),
        .forward_by_entry  (forward_by_entry),
        .entries           (entries),
        .valid_by_entry    (valid_by_entry)
    );

    issue_select u_issue_select (
        .entries          (entries),
        .wb_bus_by_bank   (wb_bus_by_bank),
        .pipeline_ready   (pipeline_ready),
        .issue_mask       (issue_mask),
        .forward_by_entry (forward_by_entry),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .prf_req_a        (prf_req_a),
        .prf_req_b        (prf_req_b)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// clock and reset generator for the BRU issue queue testbench

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES = 3;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD_NS CLK = ~CLK;
    end

    // release just after an edge, clear of the flops
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/tb_bru_iq.sv
// stimulus, reference queue model, checks, watchdog and report for the BRU issue queue testbench

`timescale 1ns/1ps
`default_nettype none

`include "bru_iq_defines.svh"

module tb_bru_iq;

    localparam int CLK_PERIOD_NS = 4;
    localparam int BANKS = 1 << `LOG_PRF_BANK_COUNT;
    localparam int RANDOM_CYCLES = 300;
    // setup phases, random phase, two drains, margin
    localparam int TIMEOUT_CYCLES = 40 + RANDOM_CYCLES + 2 * 30 + 50;

    typedef bru_iq_pkg::iq_op_t [`DISPATCH_WAYS-1:0] way_ops_t;
    typedef bru_iq_pkg::wb_bus_t [BANKS-1:0] bus_vec_t;

    logic                       CLK;
    logic                       nRST;
    logic [`DISPATCH_WAYS-1:0]  dispatch_attempt_by_way;
    way_ops_t                   dispatch_op_by_way;
    logic [`DISPATCH_WAYS-1:0]  dispatch_ack_by_way;
    logic                       pipeline_ready;
    bus_vec_t                   wb_bus_by_bank;
    logic                       issue_valid;
    bru_iq_pkg::issue_op_t      issue_op;
    bru_iq_pkg::prf_read_req_t  prf_req_a;
    bru_iq_pkg::prf_read_req_t  prf_req_b;

    // oldest op at index 0
    bru_iq_pkg::iq_op_t model_q[$];
    int error_count = 0;
    int issued_count = 0;

    tb_clock_gen clock_gen (.CLK(CLK), .nRST(nRST));

    bru_iq dut (.*);

    function automatic void flag_error(string msg);
        error_count++;
        $display("Error at time %0t: %s", $time, msg);
    endfunction

    function automatic logic operand_forwarded(bru_iq_pkg::src_operand_t src);
        bru_iq_pkg::wb_bus_t bus;
        bus = wb_bus_by_bank[src.pr[`LOG_PRF_BANK_COUNT-1:0]];
        return bus.valid && bus.upper_pr == src.pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];
    endfunction

    function automatic logic operand_usable(bru_iq_pkg::src_operand_t src);
        return src.unneeded || src.ready || operand_forwarded(src);
    endfunction

    function automatic bru_iq_pkg::iq_op_t random_op();
        bru_iq_pkg::iq_op_t op;
        op = '0;
        op.valid = 1'b1;
        op.payload.op = bru_iq_pkg::bru_op_t'($urandom);
        op.payload.pc = $urandom;
        op.payload.imm20 = bru_iq_pkg::imm20_t'($urandom);
        op.payload.dest_pr = bru_iq_pkg::pr_t'($urandom);
        op.payload.rob_index = bru_iq_pkg::rob_index_t'($urandom);
        // small register pool so the writeback bus hits often
        op.a.pr = bru_iq_pkg::pr_t'($urandom % 16);
        op.a.unneeded = ($urandom % 4) == 0;
        op.a.ready = ($urandom % 2) == 0;
        op.b.pr = bru_iq_pkg::pr_t'($urandom % 16);
        op.b.unneeded = ($urandom % 4) == 0;
        op.b.ready = ($urandom % 2) == 0;
        return op;
    endfunction

    function automatic bus_vec_t bus_for(bru_iq_pkg::pr_t pr);
        bus_vec_t bus;
        bus = '0;
        bus[pr[1:0]].valid = 1'b1;
        bus[pr[1:0]].upper_pr = pr[6:2];
        return bus;
    endfunction

    // ------------------------------------------------------------------------
    // reference model check just before the edge

    task automatic check_cycle();
        bru_iq_pkg::iq_op_t cand;
        logic [`DISPATCH_WAYS-1:0] exp_ack;
        int free_slots;
        int pick;
        logic fwd_a;
        logic fwd_b;

        free_slots = `BRU_IQ_ENTRIES - model_q.size();
        pick = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (pick < 0 && pipeline_ready && operand_usable(model_q[i].a)
                    && operand_usable(model_q[i].b)) begin
                pick = i;
            end
        end
        assert (issue_valid == (pick >= 0))
            else flag_error($sformatf("issue_valid is %0b, expected %0b", issue_valid, pick >= 0));
        if (pick >= 0) begin
            cand = model_q[pick];
            fwd_a = operand_forwarded(cand.a);
            fwd_b = operand_forwarded(cand.b);
            assert (issue_op.payload == cand.payload)
                else flag_error($sformatf("issued rob index %0d, oldest ready is %0d",
                    issue_op.payload.rob_index, cand.payload.rob_index));
            assert (issue_op.a_forward == fwd_a && issue_op.b_forward == fwd_b
                    && issue_op.a_unneeded == cand.a.unneeded
                    && issue_op.b_unneeded == cand.b.unneeded)
                else flag_error("operand forward or unneeded flags wrong");
            assert (issue_op.a_bank == cand.a.pr[1:0] && issue_op.b_bank == cand.b.pr[1:0]
                    && prf_req_a.pr == cand.a.pr && prf_req_b.pr == cand.b.pr)
                else flag_error("issue bank or read request register wrong");
            assert (prf_req_a.valid == (!fwd_a && !cand.a.unneeded)
                    && prf_req_b.valid == (!fwd_b && !cand.b.unneeded))
                else flag_error("read request valid wrong");
            model_q.delete(pick);
            issued_count++;
        end
        else begin
            assert (!prf_req_a.valid && !prf_req_b.valid)
                else flag_error("read request valid without an issue");
        end
        // wakeups land only in ops already queued
        for (int i = 0; i < model_q.size(); i++) begin
            cand = model_q[i];
            cand.a.ready = cand.a.ready | operand_forwarded(cand.a);
            cand.b.ready = cand.b.ready | operand_forwarded(cand.b);
            model_q[i] = cand;
        end
        exp_ack = '0;
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            if (dispatch_attempt_by_way[w] && free_slots > 0) begin
                exp_ack[w] = 1'b1;
                free_slots--;
                model_q.push_back(dispatch_op_by_way[w]);
            end
        end
        assert (dispatch_ack_by_way == exp_ack)
            else flag_error($sformatf("acks %b, expected %b", dispatch_ack_by_way, exp_ack));
    endtask

    task automatic drive_and_check(input logic [`DISPATCH_WAYS-1:0] attempt,
                                   input way_ops_t ops, input logic ready, input bus_vec_t bus);
        @(posedge CLK);
        #1;
        dispatch_attempt_by_way = attempt;
        dispatch_op_by_way = ops;
        pipeline_ready = ready;
        wb_bus_by_bank = bus;
        #2;
        check_cycle();
    endtask

    // every pool register shows up on every bank within four cycles
    // and once the model is empty four more sweeps must issue nothing
    task automatic drain_queue();
        bus_vec_t sweep;
        int step;
        int idle;
        step = 0;
        idle = 0;
        while (model_q.size() > 0 || idle < BANKS) begin
            if (model_q.size() == 0) begin
                idle++;
            end
            for (int b = 0; b < BANKS; b++) begin
                sweep[b].valid = 1'b1;
                sweep[b].upper_pr = bru_iq_pkg::pr_upper_t'((step + b) % 4);
            end
            drive_and_check('0, '0, 1'b1, sweep);
            step++;
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus

    initial begin
        way_ops_t way_ops;
        bus_vec_t bus;

        void'($urandom(32'h9d20_eca0));
        dispatch_attempt_by_way = '0;
        dispatch_op_by_way = '0;
        pipeline_ready = 1'b0;
        wb_bus_by_bank = '0;
        wait (nRST === 1'b1);

        drive_and_check('0, '0, 1'b0, '0);
        drive_and_check('0, '0, 1'b1, '0);

        // fill under back-pressure until the last attempt finds the queue full
        for (int c = 0; c < 3; c++) begin
            for (int w = 0; w < `DISPATCH_WAYS; w++) begin
                way_ops[w] = random_op();
            end
            drive_and_check(c == 0 ? 4'b1011 : 4'b1111, way_ops, 1'b0, '0);
        end
        drain_queue();

        // wakeup during a stall and issue later without the bus
        way_ops = '0;
        way_ops[0] = random_op();
        way_ops[0].a.pr = 7'h2d;
        way_ops[0].a.unneeded = 1'b0;
        way_ops[0].a.ready = 1'b0;
        way_ops[0].b.unneeded = 1'b1;
        drive_and_check(4'b0001, way_ops, 1'b0, '0);
        drive_and_check('0, '0, 1'b1, '0);
        drive_and_check('0, '0, 1'b0, bus_for(7'h2d));
        drive_and_check('0, '0, 1'b1, '0);

        // wakeup and issue in the same cycle
        way_ops = '0;
        way_ops[2] = random_op();
        way_ops[2].a.unneeded = 1'b1;
        way_ops[2].b.pr = 7'h13;
        way_ops[2].b.unneeded = 1'b0;
        way_ops[2].b.ready = 1'b0;
        drive_and_check(4'b0100, way_ops, 1'b0, '0);
        drive_and_check('0, '0, 1'b1, '0);
        drive_and_check('0, '0, 1'b1, bus_for(7'h13));

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            for (int w = 0; w < `DISPATCH_WAYS; w++) begin
                way_ops[w] = random_op();
            end
            for (int b = 0; b < BANKS; b++) begin
                bus[b].valid = ($urandom % 2) == 0;
                bus[b].upper_pr = bru_iq_pkg::pr_upper_t'($urandom % 4);
            end
            drive_and_check(`DISPATCH_WAYS'($urandom), way_ops, ($urandom % 4) != 0, bus);
        end
        drain_queue();

        $display("tb_bru_iq done: %0d ops issued, %0d errors", issued_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end
        else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/bru_iq_pkg.sv
design/dispatch_alloc.sv
design/iq_entry_array.sv
design/issue_select.sv
design/bru_iq.sv
tb/tb_clock_gen.sv
tb/tb_bru_iq.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass message shows up
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module tb_bru_iq &&
    ./obj_dir/Vtb_bru_iq | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
